// ==== testbench/warpSe_golden.txt ====
# rw byteAddr uds lds reply(a=ack e=err) delay term(D V B) chip row col
# row = A[21:11], col = {0, A[10:1]}; row/col are 000 for non-ram lines
r 012346 0 0 a 0 D ram 024 1A3
w 3FFFFE 0 1 a 0 D ram 7FF 3FF
w 000000 0 0 a 0 D ram 000 000
r 400000 0 0 a 0 D rom 000 000
r 4ABCDE 0 0 a 0 D rom 000 000
r 800010 0 0 a 3 D io 000 000
w E00020 1 0 e 2 B io 000 000
r 9FFFFE 0 0 a 0 D io 000 000
r 500000 0 0 a 0 B none 000 000
r 7FFFFE 0 0 a 0 B none 000 000
r FFFFF6 0 0 a 0 V none 000 000
w 155554 1 0 a 0 D ram 2AA 2AA
r 2AAAAA 0 0 a 0 D ram 555 155
r C00000 0 0 a 7 D io 000 000
r 0007FE 0 0 a 0 D ram 000 3FF
r 400002 0 0 a 0 D rom 000 000
w 200800 0 0 a 0 D ram 401 000
w A00000 0 0 e 5 B io 000 000

// ==== tb.f ====
src/warpPkg.sv
src/addrDecode.sv
src/refreshTimer.sv
src/dramTiming.sv
src/ioBridge.sv
src/fsbCtrl.sv
src/warpSe.sv
testbench/warpSe_chk.sv
testbench/warpSe_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the warpSe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f tb.f --top-module warpSe_tb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
	exit 1
fi
exit 0

// ==== testbench/warpSe_tb.sv ====
`timescale 1ns/1ps

module warpSe_tb;

	logic FCLK, rstN, asFsbN, udsFsbN, ldsFsbN, weFsbN, dtackIobN, berrIobN;
	warpPkg::cpuAddr addr;
	logic dtackFsbN, vpaFsbN, berrFsbN, rasN, casN, lweN, uweN, romCsN;
	logic asIobN, udsIobN, ldsIobN, rwIob;
	warpPkg::dramAddr ra;
	warpPkg::cpuAddr ioAddr;

	// one golden entry per cpu cycle
	logic [7:0] gRw[32], gErr[32], gTerm[32];
	logic [23:0] gAddr[32];
	logic gUds[32], gLds[32];
	int gDelay[32];
	logic [31:0] gChip[32];
	logic [10:0] gRow[32], gCol[32];
	int lines = 0, limitCycles = 0, errors = 0, checks = 0;

	// state of the cycle in flight for the monitor
	logic inCycle = 0, rasSeen, casSeen, ioSeen, expLwe, expUwe, expUds, expLds;
	logic errReply; // slow bus answers with berr
	logic [31:0] chipS;
	logic [10:0] expRow, expCol;
	int curDelay, ioLow, cyc, refreshCount = 0, elapsed = 0, ioSpan = 0;
	logic rasPrev = 1, casPrev = 1, asIobPrev = 1, dtackPrev = 1;
	logic refActive = 0; // cas-before-ras in progress

	warpSe dut_i (.*);

	initial begin
		FCLK = 0;
		forever #50 FCLK = ~FCLK; // 100 ns
	end

	task automatic noteMismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("Fail t=%0t %s got=%h exp=%h", $time, sig, got, exp);
	endtask

	task automatic flagProblem(input string msg);
		errors++;
		$display("Error t=%0t %s", $time, msg);
	endtask

	function automatic logic termLow();
		return !dtackFsbN || !vpaFsbN || !berrFsbN;
	endfunction

	// slow-bus responder answers after the listed delay
	always @(posedge FCLK) begin
		if (asIobN) begin
			dtackIobN <= 1'b1;
			berrIobN <= 1'b1;
			ioLow <= 0;
		end else begin
			ioLow <= ioLow + 1;
			if (ioLow == curDelay) begin
				if (chipS == "io" && errReply) berrIobN <= 1'b0;
				else dtackIobN <= 1'b0;
			end
		end
	end

	// monitor samples mid-period where everything is stable
	always @(negedge FCLK) begin
		if (rstN) begin
			elapsed++;
			if (!casN && casPrev && rasN) begin // cas before ras
				refreshCount++;
				refActive = 1;
			end
			if (casN) refActive = 0;
			if (!rasN && rasPrev && casN) begin // access row strobe
				checks++;
				assert (inCycle && chipS == "ram")
					else flagProblem("RAS fell outside a RAM cycle");
				if (chipS == "ram") begin
					assert (ra == expRow) else noteMismatch("ra(row)", ra, expRow);
					rasSeen = 1;
				end
			end
			if (!casN && casPrev && !rasN) begin // column strobe
				checks += 3;
				assert (ra == expCol) else noteMismatch("ra(col)", ra, expCol);
				assert (lweN == expLwe) else noteMismatch("lweN", lweN, expLwe);
				assert (uweN == expUwe) else noteMismatch("uweN", uweN, expUwe);
				casSeen = 1;
			end
			if (!dtackFsbN && dtackPrev && chipS == "ram") begin // ram cycle ends
				checks++;
				assert (!(refActive && !rasN))
					else flagProblem("RAM cycle terminated during a refresh");
			end
			if (!asIobN && asIobPrev) begin // slow bus cycle starts
				checks += 4;
				ioSeen = 1;
				ioSpan = 0;
				assert (ioAddr == addr) else noteMismatch("ioAddr", ioAddr, addr);
				assert (rwIob == weFsbN) else noteMismatch("rwIob", rwIob, weFsbN);
				assert (udsIobN == expUds) else noteMismatch("udsIobN", udsIobN, expUds);
				assert (ldsIobN == expLds) else noteMismatch("ldsIobN", ldsIobN, expLds);
			end
			if (!asIobN) ioSpan++;
			if (asIobN && !asIobPrev) begin
				checks++;
				assert (ioSpan == curDelay + 2) else noteMismatch("asIobN low cycles", ioSpan,
					curDelay + 2);
			end
			rasPrev = rasN;
			casPrev = casN;
			asIobPrev = asIobN;
			dtackPrev = dtackFsbN;
		end
	end

	// one cpu cycle from AS low to all terminations released
	task automatic runCycle(input int i);
		logic [23:0] a;
		logic [7:0] gotTerm;
		a = gAddr[i];
		chipS = gChip[i];
		expRow = gRow[i];
		expCol = gCol[i];
		// write strobes follow the byte lanes on writes only
		expLwe = (gRw[i] == "w") ? gLds[i] : 1'b1;
		expUwe = (gRw[i] == "w") ? gUds[i] : 1'b1;
		expUds = gUds[i];
		expLds = gLds[i];
		curDelay = gDelay[i];
		errReply = (gErr[i] == "e");
		rasSeen = 0;
		casSeen = 0;
		ioSeen = 0;
		@(posedge FCLK);
		addr <= a[23:1];
		weFsbN <= (gRw[i] == "r");
		udsFsbN <= gUds[i];
		ldsFsbN <= gLds[i];
		asFsbN <= 1'b0;
		inCycle = 1;
		cyc = -1;
		@(negedge FCLK); // before cycle 0
		do begin
			@(negedge FCLK);
			cyc++;
			if (chipS == "rom" && cyc >= 2) begin
				assert (!romCsN) else noteMismatch("romCsN", romCsN, 0);
			end
		end while (!termLow());
		gotTerm = !dtackFsbN ? "D" : (!vpaFsbN ? "V" : "B");
		checks++;
		assert (gotTerm == gTerm[i]) else noteMismatch("termination", gotTerm, gTerm[i]);
		if (chipS == "rom") begin
			checks++;
			assert (cyc == warpPkg::romWait + 2) else noteMismatch("rom dtack cycle", cyc,
				warpPkg::romWait + 2);
		end
		if (chipS == "ram") begin
			checks++;
			assert (rasSeen && casSeen) else flagProblem("RAM cycle without RAS and CAS");
		end
		if (chipS == "io") begin
			checks++;
			assert (ioSeen && asIobN) else flagProblem("termination before slow bus reply");
		end
		@(posedge FCLK);
		asFsbN <= 1'b1;
		udsFsbN <= 1'b1;
		ldsFsbN <= 1'b1;
		do begin
			@(negedge FCLK);
			if (chipS == "rom" && termLow()) begin
				assert (!romCsN) else noteMismatch("romCsN", romCsN, 0);
			end
		end while (termLow());
		@(posedge FCLK);
		inCycle = 0;
		repeat ($urandom % 41) @(posedge FCLK); // idle gap
	endtask

	// watchdog armed once the table is loaded
	initial begin
		wait (limitCycles > 0);
		repeat (limitCycles) @(posedge FCLK);
		$display("watchdog ran out after %0d cycles", limitCycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int fd, n, maxDelay;
		string line;
		logic [31:0] row, col;
		rstN = 0;
		asFsbN = 1;
		udsFsbN = 1;
		ldsFsbN = 1;
		weFsbN = 1;
		dtackIobN = 1;
		berrIobN = 1;
		addr = '0;
		curDelay = 0;
		errReply = 0;
		chipS = "none";
		void'($urandom(43));
		maxDelay = 0;
		fd = $fopen("testbench/warpSe_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open golden file");
			$display("TEST FAILED");
			$finish;
		end else begin
			while (!$feof(fd) && lines < 32) begin
				n = $fgets(line, fd);
				if (n > 0 && line[0] != "#") begin
					n = $sscanf(line, "%s %h %b %b %s %d %s %s %h %h", gRw[lines], gAddr[lines],
						gUds[lines], gLds[lines], gErr[lines], gDelay[lines], gTerm[lines],
						gChip[lines], row, col);
					if (n == 10) begin
						gRow[lines] = row[10:0];
						gCol[lines] = col[10:0];
						if (gDelay[lines] > maxDelay) maxDelay = gDelay[lines];
						lines++;
					end
				end
			end
			$fclose(fd);
			limitCycles = lines * (maxDelay + 60) + 200;
			repeat (8) @(posedge FCLK);
			rstN <= 1'b1;
			for (int i = 0; i < lines; i++) runCycle(i);
			checks++;
			assert (refreshCount + 1 >= elapsed / warpPkg::refreshPeriod
				&& refreshCount <= elapsed / warpPkg::refreshPeriod + 1)
				else noteMismatch("refresh count", refreshCount, elapsed / warpPkg::refreshPeriod);
			$display("cycles=%0d checks=%0d errors=%0d refreshes=%0d", lines, checks, errors,
				refreshCount);
			if (errors == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

// ==== testbench/warpSe_chk.sv ====
`timescale 1ns/1ps

module warpSe_chk (
	input logic FCLK,
	input logic rstN,
	input logic asFsbN,
	input logic dtackFsbN,
	input logic vpaFsbN,
	input logic berrFsbN,
	input logic rasN,
	input logic casN,
	input logic ramReady
);

	logic anyTerm;
	assign anyTerm = !dtackFsbN || !vpaFsbN || !berrFsbN;

	// one termination per cpu cycle
	oneTerm: assert property (@(posedge FCLK) disable iff (!rstN)
		$countones({!dtackFsbN, !vpaFsbN, !berrFsbN}) <= 1)
		else $error("more than one termination low");

	// released within two edges of AS going high
	termRelease: assert property (@(posedge FCLK) disable iff (!rstN)
		(asFsbN && anyTerm) |-> ##[1:2] !anyTerm)
		else $error("termination held after AS released");

	// access cas only with ras already low
	casAfterRas: assert property (@(posedge FCLK) disable iff (!rstN)
		($fell(casN) && $rose(ramReady)) |-> !rasN)
		else $error("CAS fell before RAS in a RAM access");

endmodule

bind warpSe warpSe_chk chk_i (.*);

// ==== src/warpSe.sv ====
`timescale 1ns/1ps

module warpSe (
	input logic FCLK,
	input logic rstN,
	input warpPkg::cpuAddr addr,
	input logic asFsbN,
	input logic udsFsbN,
	input logic ldsFsbN,
	input logic weFsbN,
	input logic dtackIobN,
	input logic berrIobN,
	output logic dtackFsbN,
	output logic vpaFsbN,
	output logic berrFsbN,
	output warpPkg::dramAddr ra,
	output logic rasN,
	output logic casN,
	output logic lweN,
	output logic uweN,
	output logic romCsN,
	output logic asIobN,
	output logic udsIobN,
	output logic ldsIobN,
	output logic rwIob,
	output warpPkg::cpuAddr ioAddr
);

	warpPkg::regionT region;
	logic ramStart, ramReady; // fsb <-> dram
	logic ioStart, ioDone, ioErr; // fsb <-> slow bus
	logic cycleEnd;
	logic refReq, refAck;

	addrDecode decode_i (.addr(addr), .region(region));

	fsbCtrl fsb_i (
		.FCLK(FCLK), .rstN(rstN), .asFsbN(asFsbN), .region(region),
		.ramReady(ramReady), .ioDone(ioDone), .ioErr(ioErr),
		.ramStart(ramStart), .ioStart(ioStart), .cycleEnd(cycleEnd),
		.romCsN(romCsN), .dtackFsbN(dtackFsbN), .vpaFsbN(vpaFsbN), .berrFsbN(berrFsbN)
	);

	dramTiming dram_i (
		.FCLK(FCLK), .rstN(rstN), .addr(addr), .weFsbN(weFsbN),
		.udsFsbN(udsFsbN), .ldsFsbN(ldsFsbN), .ramStart(ramStart),
		.cycleEnd(cycleEnd), .refReq(refReq), .refAck(refAck), .ramReady(ramReady),
		.ra(ra), .rasN(rasN), .casN(casN), .lweN(lweN), .uweN(uweN)
	);

	refreshTimer refresh_i (.FCLK(FCLK), .rstN(rstN), .refAck(refAck), .refReq(refReq));

	ioBridge io_i (
		.FCLK(FCLK), .rstN(rstN), .addr(addr), .weFsbN(weFsbN),
		.udsFsbN(udsFsbN), .ldsFsbN(ldsFsbN), .ioStart(ioStart), .cycleEnd(cycleEnd),
		.dtackIobN(dtackIobN), .berrIobN(berrIobN), .ioDone(ioDone), .ioErr(ioErr),
		.ioAddr(ioAddr), .asIobN(asIobN), .udsIobN(udsIobN), .ldsIobN(ldsIobN),
		.rwIob(rwIob)
	);

endmodule

// ==== src/fsbCtrl.sv ====
`timescale 1ns/1ps

module fsbCtrl (
	input logic FCLK,
	input logic rstN,
	input logic asFsbN,
	input warpPkg::regionT region,
	input logic ramReady,
	input logic ioDone,
	input logic ioErr,
	output logic ramStart,
	output logic ioStart,
	output logic cycleEnd,
	output logic romCsN,
	output logic dtackFsbN,
	output logic vpaFsbN,
	output logic berrFsbN
);

	warpPkg::fsbStateT state;
	warpPkg::regionT regQ; // region held from cycle 1
	logic decPhase; // second decode cycle, dispatch
	warpPkg::wsCnt waitCnt; // rom wait states left

	always_ff @(posedge FCLK) begin
		if (!rstN) begin
			state <= warpPkg::idle;
			regQ <= warpPkg::regNone;
			decPhase <= 1'b0;
			waitCnt <= '0;
			ramStart <= 1'b0;
			ioStart <= 1'b0;
			cycleEnd <= 1'b0;
			romCsN <= 1'b1;
			dtackFsbN <= 1'b1;
			vpaFsbN <= 1'b1;
			berrFsbN <= 1'b1;
		end else begin
			ramStart <= 1'b0; // pulses
			ioStart <= 1'b0;
			cycleEnd <= 1'b0;
			case (state)
				warpPkg::idle: if (!asFsbN) state <= warpPkg::decode; // cycle 0
				warpPkg::decode: begin
					decPhase <= !decPhase;
					if (!decPhase) begin
						regQ <= region; // cycle 1
					end else begin // cycle 2, dispatch
						case (regQ)
							warpPkg::regRam: begin
								ramStart <= 1'b1;
								state <= warpPkg::waitRam;
							end
							warpPkg::regRom: begin
								romCsN <= 1'b0;
								waitCnt <= warpPkg::romWaitLoad;
								state <= warpPkg::waitRom;
							end
							warpPkg::regIo: begin
								ioStart <= 1'b1;
								state <= warpPkg::waitIo;
							end
							warpPkg::regIack: begin
								vpaFsbN <= 1'b0; // autovector
								state <= warpPkg::term;
							end
							default: begin
								berrFsbN <= 1'b0; // unmapped
								state <= warpPkg::term;
							end
						endcase
					end
				end
				warpPkg::waitRam: if (ramReady) begin
					dtackFsbN <= 1'b0;
					state <= warpPkg::term;
				end
				warpPkg::waitRom: begin
					if (waitCnt == '0) begin
						dtackFsbN <= 1'b0; // cycle 2 + romWait
						state <= warpPkg::term;
					end else begin
						waitCnt <= waitCnt - 1'b1;
					end
				end
				warpPkg::waitIo: if (ioDone) begin
					if (ioErr) berrFsbN <= 1'b0;
					else dtackFsbN <= 1'b0;
					state <= warpPkg::term;
				end
				warpPkg::term: if (asFsbN) begin // cpu let go of AS
					cycleEnd <= 1'b1;
					state <= warpPkg::hold;
				end
				warpPkg::hold: begin
					romCsN <= 1'b1;
					dtackFsbN <= 1'b1;
					vpaFsbN <= 1'b1;
					berrFsbN <= 1'b1;
					state <= warpPkg::idle;
				end
				default: state <= warpPkg::idle;
			endcase
		end
	end

endmodule

// ==== src/ioBridge.sv ====
`timescale 1ns/1ps

module ioBridge (
	input logic FCLK,
	input logic rstN,
	input warpPkg::cpuAddr addr,
	input logic weFsbN,
	input logic udsFsbN,
	input logic ldsFsbN,
	input logic ioStart,
	input logic cycleEnd,
	input logic dtackIobN,
	input logic berrIobN,
	output logic ioDone,
	output logic ioErr,
	output warpPkg::cpuAddr ioAddr,
	output logic asIobN,
	output logic udsIobN,
	output logic ldsIobN,
	output logic rwIob
);

	typedef enum logic [1:0] {
		iIdle,
		iBus, // strobes out, waiting on slow bus
		iDone // result held for fsbCtrl
	} ioStateT;

	ioStateT state;
	logic slowReply;

	assign slowReply = !dtackIobN || !berrIobN;

	// address latched once per slow-bus cycle
	always_ff @(posedge FCLK) begin
		if (state == iIdle && ioStart) ioAddr <= addr;
	end

	always_ff @(posedge FCLK) begin
		if (!rstN) begin
			state <= iIdle;
			ioDone <= 1'b0;
			ioErr <= 1'b0;
			asIobN <= 1'b1;
			udsIobN <= 1'b1;
			ldsIobN <= 1'b1;
			rwIob <= 1'b1; // read
		end else begin
			case (state)
				iIdle: if (ioStart) begin
					asIobN <= 1'b0;
					udsIobN <= udsFsbN; // byte lanes from cpu
					ldsIobN <= ldsFsbN;
					rwIob <= weFsbN;
					state <= iBus;
				end
				iBus: if (slowReply) begin // any length of wait
					asIobN <= 1'b1;
					udsIobN <= 1'b1;
					ldsIobN <= 1'b1;
					ioDone <= 1'b1;
					ioErr <= !berrIobN; // err beats ack if both
					state <= iDone;
				end
				iDone: if (cycleEnd) begin
					ioDone <= 1'b0;
					ioErr <= 1'b0;
					rwIob <= 1'b1;
					state <= iIdle;
				end
				default: state <= iIdle;
			endcase
		end
	end

endmodule

// ==== src/dramTiming.sv ====
`timescale 1ns/1ps

module dramTiming (
	input logic FCLK,
	input logic rstN,
	input warpPkg::cpuAddr addr,
	input logic weFsbN,
	input logic udsFsbN,
	input logic ldsFsbN,
	input logic ramStart,
	input logic cycleEnd,
	input logic refReq,
	output logic refAck,
	output logic ramReady,
	output warpPkg::dramAddr ra,
	output logic rasN,
	output logic casN,
	output logic lweN,
	output logic uweN
);

	typedef enum logic [2:0] {
		dIdle,
		dRow, // ras low, row on ra
		dCol, // column on ra
		dAccess, // cas low, wait for cycleEnd
		dRefCas, // refresh, cas first
		dRefRas // refresh, ras+cas held
	} dramStateT;

	dramStateT state;
	logic startPending; // ramStart seen during a refresh
	warpPkg::holdCnt holdCount;

	// ra is a payload register, loaded on row and column steps
	always_ff @(posedge FCLK) begin
		if (state == dIdle) begin
			ra <= addr[21:11]; // row
		end else if (state == dRow) begin
			ra <= {1'b0, addr[10:1]}; // column, zero on top
		end
	end

	always_ff @(posedge FCLK) begin
		if (!rstN) begin
			state <= dIdle;
			startPending <= 1'b0;
			holdCount <= '0;
			refAck <= 1'b0;
			ramReady <= 1'b0;
			rasN <= 1'b1;
			casN <= 1'b1;
			lweN <= 1'b1;
			uweN <= 1'b1;
		end else begin
			refAck <= 1'b0; // one-cycle pulse
			if (ramStart) startPending <= 1'b1;
			case (state)
				dIdle: begin
					if (refReq) begin // refresh wins over new access
						refAck <= 1'b1;
						casN <= 1'b0;
						state <= dRefCas;
					end else if (ramStart || startPending) begin
						startPending <= 1'b0;
						rasN <= 1'b0;
						state <= dRow;
					end
				end
				dRow: state <= dCol;
				dCol: begin
					casN <= 1'b0;
					ramReady <= 1'b1; // rises with cas
					lweN <= weFsbN | ldsFsbN;
					uweN <= weFsbN | udsFsbN;
					state <= dAccess;
				end
				dAccess: begin
					lweN <= weFsbN | ldsFsbN; // track byte strobes
					uweN <= weFsbN | udsFsbN;
					if (cycleEnd) begin
						rasN <= 1'b1;
						casN <= 1'b1;
						lweN <= 1'b1;
						uweN <= 1'b1;
						ramReady <= 1'b0;
						state <= dIdle; // deferred refresh goes next
					end
				end
				dRefCas: begin
					rasN <= 1'b0;
					holdCount <= warpPkg::refHoldLoad;
					state <= dRefRas;
				end
				dRefRas: begin
					if (holdCount == '0) begin
						rasN <= 1'b1; // release together
						casN <= 1'b1;
						state <= dIdle;
					end else begin
						holdCount <= holdCount - 1'b1;
					end
				end
				default: state <= dIdle;
			endcase
		end
	end

endmodule

// ==== src/refreshTimer.sv ====
`timescale 1ns/1ps

module refreshTimer (
	input logic FCLK,
	input logic rstN,
	input logic refAck,
	output logic refReq
);

	warpPkg::refCnt refCount; // cycles left to next request

	// down-counter, parks at zero while request is pending
	always_ff @(posedge FCLK) begin
		if (!rstN) begin
			refCount <= warpPkg::refreshLoad;
			refReq <= 1'b0;
		end else if (refAck) begin
			refCount <= warpPkg::refreshLoad; // restart at ack
			refReq <= 1'b0;
		end else if (refCount == '0) begin
			refReq <= 1'b1; // hold until dram side takes it
		end else begin
			refCount <= refCount - 1'b1;
		end
	end

	// refReq is a level, not a pulse. dramTiming may sit on it for a whole
	// ram access, so the counter waits rather than queueing a second one.

endmodule

// ==== src/addrDecode.sv ====
`timescale 1ns/1ps

module addrDecode (
	input warpPkg::cpuAddr addr,
	output warpPkg::regionT region
);

	warpPkg::mapNibble nibble; // top address nibble
	logic inRam;
	logic inIo;

	assign nibble = addr[23:20];
	assign inRam = (addr[23:22] == warpPkg::ramTop); // nibbles 0..3
	assign inIo = (nibble >= warpPkg::ioLowNibble) && (nibble <= warpPkg::ioHighNibble);

	// one region per cycle, ram first
	always_comb begin
		if (inRam) begin
			region = warpPkg::regRam;
		end else if (nibble == warpPkg::romNibble) begin
			region = warpPkg::regRom;
		end else if (inIo) begin
			region = warpPkg::regIo;
		end else if (nibble == warpPkg::iackNibble) begin
			region = warpPkg::regIack; // cpu space, int ack
		end else begin
			region = warpPkg::regNone; // 5..7 unmapped -> berr
		end
	end

	// Nibbles 5, 6 and 7 fall through to regNone. Nothing else in the
	// design looks at address bits to pick a target, so any change to the
	// card's memory map is made here and in the package constants.

endmodule

// ==== src/warpPkg.sv ====
package warpPkg;

	// cpu word address, numbered as on the bus (A23..A1)
	typedef logic [23:1] cpuAddr;
	typedef logic [10:0] dramAddr; // multiplexed RA lines
	typedef logic [3:0] mapNibble; // A[23:20]

	typedef enum logic [2:0] {
		regRam,
		regRom,
		regIo,
		regIack,
		regNone
	} regionT;

	typedef enum logic [2:0] {
		idle,
		decode,
		waitRam,
		waitRom,
		waitIo,
		term,
		hold
	} fsbStateT;

	// memory map
	localparam logic [1:0] ramTop = 2'd0; // A[23:22] == 0 -> 4 MB ram
	localparam mapNibble romNibble = 4'd4;
	localparam mapNibble ioLowNibble = 4'd8;
	localparam mapNibble ioHighNibble = 4'd14; // io window inclusive
	localparam mapNibble iackNibble = 4'd15;

	// DRAM mux: row = A[21:11], column = {1'b0, A[10:1]}

	localparam int romWait = 3; // rom wait states
	typedef logic [$clog2(romWait + 1) - 1:0] wsCnt;
	localparam wsCnt romWaitLoad = wsCnt'(romWait - 1);

	localparam int refreshPeriod = 64; // short for sim
	typedef logic [$clog2(refreshPeriod) - 1:0] refCnt;
	localparam refCnt refreshLoad = refCnt'(refreshPeriod - 1);

	localparam int refHold = 2; // ras+cas overlap during refresh
	typedef logic [$clog2(refHold + 1) - 1:0] holdCnt;
	localparam holdCnt refHoldLoad = holdCnt'(refHold - 1);

endpackage
